/* rtl/serial_bus_pkg.sv */
package serial_bus_pkg;

    // word and memory geometry
    localparam int DATA_WIDTH = 32;
    localparam int MEM_DEPTH  = 2000;
    localparam int ADDR_WIDTH = 11;
    localparam int SID_WIDTH  = 2;

    // command frame layout: start(3) | id(2) | rw | burst | addr(11), msb first
    localparam int FRAME_BITS = 18;
    localparam logic [2:0] START_CODE = 3'b111;
    localparam int START_LSB  = 15;
    localparam int SID_LSB    = 13;
    localparam int RW_POS     = 12;
    localparam int BURST_POS  = 11;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [SID_WIDTH-1:0]  slave_id_t;
    typedef logic [FRAME_BITS-1:0] frame_t;

    // holds 0 to DATA_WIDTH inclusive
    typedef logic [5:0] bit_count_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RECV,
        READ_FETCH,
        READ_SEND
    } ctrl_state_t;

endpackage

/* rtl/frame_receiver.sv */
`timescale 1ns/1ps

module frame_receiver #(
    parameter serial_bus_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  control,
    output logic                  cmd_valid,
    output logic                  cmd_write,
    output logic                  cmd_burst,
    output serial_bus_pkg::addr_t cmd_addr
);

    serial_bus_pkg::frame_t     frame;
    serial_bus_pkg::frame_t     next_frame;
    serial_bus_pkg::bit_count_t bit_cnt;
    logic                       shifting;
    logic                       frame_end;
    logic                       frame_match;

    assign next_frame = {frame[serial_bus_pkg::FRAME_BITS-2:0], control};

    // counter shows bits already taken, so the 18th bit arrives at FRAME_BITS-1
    assign frame_end = shifting &&
        (bit_cnt == serial_bus_pkg::bit_count_t'(serial_bus_pkg::FRAME_BITS - 1));

    assign frame_match =
        (next_frame[serial_bus_pkg::START_LSB +: 3] == serial_bus_pkg::START_CODE) &&
        (next_frame[serial_bus_pkg::SID_LSB +: serial_bus_pkg::SID_WIDTH] == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shifting  <= 1'b0;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (!shifting) begin
                // a high control bit while idle is the first start bit
                if (control) begin
                    shifting <= 1'b1;
                    bit_cnt  <= serial_bus_pkg::bit_count_t'(1);
                end
            end else if (frame_end) begin
                shifting  <= 1'b0;
                bit_cnt   <= '0;
                cmd_valid <= frame_match;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shifting || control) begin
            frame <= next_frame;
        end
    end

    // decoded fields are read straight from the completed frame
    assign cmd_write = frame[serial_bus_pkg::RW_POS];
    assign cmd_burst = frame[serial_bus_pkg::BURST_POS];
    assign cmd_addr  = frame[serial_bus_pkg::ADDR_WIDTH-1:0];

    // frames are separated by at least one low control cycle
    a_frame_gap: assert property (@(posedge clk) disable iff (!rstN)
        frame_end |=> !control);

endmodule

/* rtl/write_deserializer.sv */
`timescale 1ns/1ps

module write_deserializer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wD,
    input  logic                  valid,
    input  logic                  last,
    input  logic                  collect,
    output logic                  word_valid,
    output logic                  word_last,
    output serial_bus_pkg::data_t word
);

    serial_bus_pkg::bit_count_t bit_cnt;
    logic                       take;
    logic                       final_bit;

    assign take      = collect && valid;
    assign final_bit =
        (bit_cnt == serial_bus_pkg::bit_count_t'(serial_bus_pkg::DATA_WIDTH - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (!collect) begin
                bit_cnt <= '0;
            end else if (valid) begin
                if (final_bit) begin
                    bit_cnt    <= '0;
                    word_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // msb arrives first and ends up at the top after 32 shifts
    always_ff @(posedge clk) begin
        if (take) begin
            word <= {word[serial_bus_pkg::DATA_WIDTH-2:0], wD};
            if (final_bit) begin
                word_last <= last;
            end
        end
    end

endmodule

/* rtl/transfer_controller.sv */
`timescale 1ns/1ps

module transfer_controller (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cmd_valid,
    input  logic                  cmd_write,
    input  logic                  cmd_burst,
    input  serial_bus_pkg::addr_t cmd_addr,
    input  logic                  word_valid,
    input  logic                  word_last,
    input  serial_bus_pkg::data_t word,
    input  logic                  word_sent,
    input  logic                  last,
    output logic                  collect,
    output logic                  wr_en,
    output logic                  rd_en,
    output logic                  load,
    output serial_bus_pkg::addr_t addr,
    output serial_bus_pkg::data_t wr_data,
    output logic                  busy_read
);

    serial_bus_pkg::ctrl_state_t state;
    logic                        burst;

    assign collect = (state == serial_bus_pkg::WRITE_RECV);

    // a finished word goes to memory in the same cycle it is reported
    assign wr_en   = (state == serial_bus_pkg::WRITE_RECV) && word_valid;
    assign wr_data = word;

    assign rd_en     = (state == serial_bus_pkg::READ_FETCH);
    assign busy_read = (state == serial_bus_pkg::READ_FETCH) ||
                       (state == serial_bus_pkg::READ_SEND);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= serial_bus_pkg::IDLE;
            burst <= 1'b0;
            addr  <= '0;
            load  <= 1'b0;
        end else begin
            // memory output is registered, so load trails the fetch by one cycle
            load <= (state == serial_bus_pkg::READ_FETCH);

            case (state)
                serial_bus_pkg::IDLE: begin
                    if (cmd_valid) begin
                        addr  <= cmd_addr;
                        burst <= cmd_burst;
                        state <= cmd_write ? serial_bus_pkg::WRITE_RECV
                                           : serial_bus_pkg::READ_FETCH;
                    end
                end

                serial_bus_pkg::WRITE_RECV: begin
                    if (word_valid) begin
                        addr <= addr + 1'b1;
                        if (!burst || word_last) begin
                            state <= serial_bus_pkg::IDLE;
                        end
                    end
                end

                serial_bus_pkg::READ_FETCH: begin
                    state <= serial_bus_pkg::READ_SEND;
                end

                serial_bus_pkg::READ_SEND: begin
                    // last is judged together with the final bit of the word
                    if (word_sent) begin
                        if (!burst || last) begin
                            state <= serial_bus_pkg::IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= serial_bus_pkg::READ_FETCH;
                        end
                    end
                end

                default: begin
                    state <= serial_bus_pkg::IDLE;
                end
            endcase
        end
    end

    // a finished word only arrives while words are being collected
    a_word_collected: assert property (@(posedge clk) disable iff (!rstN)
        word_valid |-> collect);

endmodule

/* rtl/word_memory.sv */
`timescale 1ns/1ps

module word_memory (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  serial_bus_pkg::addr_t addr,
    input  serial_bus_pkg::data_t wr_data,
    output serial_bus_pkg::data_t rd_data
);

    serial_bus_pkg::data_t mem [serial_bus_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // read data appears the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

    // 11 address bits reach past the last word
    a_addr_range: assert property (@(posedge clk)
        (wr_en || rd_en) |-> (addr < serial_bus_pkg::MEM_DEPTH));

endmodule

/* rtl/read_serializer.sv */
`timescale 1ns/1ps

module read_serializer (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  load,
    input  serial_bus_pkg::data_t rd_data,
    input  logic                  busy_read,
    output logic                  rD,
    output logic                  ready,
    output logic                  word_sent
);

    serial_bus_pkg::data_t      shreg;
    serial_bus_pkg::bit_count_t bit_cnt;
    logic                       shifting;

    // bit_cnt counts bits already placed on rD
    assign word_sent = shifting &&
        (bit_cnt == serial_bus_pkg::bit_count_t'(serial_bus_pkg::DATA_WIDTH));

    // low only in the fetch gaps of a read
    assign ready = shifting || !busy_read;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shifting <= 1'b0;
            bit_cnt  <= '0;
            rD       <= 1'b0;
        end else if (load) begin
            shifting <= 1'b1;
            bit_cnt  <= serial_bus_pkg::bit_count_t'(1);
            rD       <= rd_data[serial_bus_pkg::DATA_WIDTH-1];
        end else if (word_sent) begin
            shifting <= 1'b0;
            bit_cnt  <= '0;
            rD       <= 1'b0;
        end else if (shifting) begin
            bit_cnt <= bit_cnt + 1'b1;
            rD      <= shreg[serial_bus_pkg::DATA_WIDTH-1];
        end
    end

    // the msb leaves on load, the rest follow from the top of shreg
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {rd_data[serial_bus_pkg::DATA_WIDTH-2:0], 1'b0};
        end else if (shifting) begin
            shreg <= {shreg[serial_bus_pkg::DATA_WIDTH-2:0], 1'b0};
        end
    end

    a_load_idle: assert property (@(posedge clk) disable iff (!rstN)
        load |-> !shifting);

endmodule

/* rtl/serial_slave.sv */
`timescale 1ns/1ps

module serial_slave #(
    parameter serial_bus_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    logic                  cmd_valid;
    logic                  cmd_write;
    logic                  cmd_burst;
    serial_bus_pkg::addr_t cmd_addr;

    logic                  collect;
    logic                  word_valid;
    logic                  word_last;
    serial_bus_pkg::data_t word;

    logic                  wr_en;
    logic                  rd_en;
    serial_bus_pkg::addr_t addr;
    serial_bus_pkg::data_t wr_data;
    serial_bus_pkg::data_t rd_data;

    logic                  load;
    logic                  word_sent;
    logic                  busy_read;

    // input side
    frame_receiver #(
        .SLAVE_ID (SLAVE_ID)
    ) u_frame_receiver (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_burst (cmd_burst),
        .cmd_addr  (cmd_addr)
    );

    write_deserializer u_write_deserializer (
        .clk        (clk),
        .rstN       (rstN),
        .wD         (wD),
        .valid      (valid),
        .last       (last),
        .collect    (collect),
        .word_valid (word_valid),
        .word_last  (word_last),
        .word       (word)
    );

    // processing
    transfer_controller u_transfer_controller (
        .clk        (clk),
        .rstN       (rstN),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_burst  (cmd_burst),
        .cmd_addr   (cmd_addr),
        .word_valid (word_valid),
        .word_last  (word_last),
        .word       (word),
        .word_sent  (word_sent),
        .last       (last),
        .collect    (collect),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .load       (load),
        .addr       (addr),
        .wr_data    (wr_data),
        .busy_read  (busy_read)
    );

    word_memory u_word_memory (
        .clk     (clk),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    // output side
    read_serializer u_read_serializer (
        .clk       (clk),
        .rstN      (rstN),
        .load      (load),
        .rd_data   (rd_data),
        .busy_read (busy_read),
        .rD        (rD),
        .ready     (ready),
        .word_sent (word_sent)
    );

endmodule

/* sim/serial_slave_tb.sv */
`timescale 1ns/1ps

module serial_slave_tb;

    localparam int TIMEOUT_CYCLES = 3000;

    logic clk = 1'b0;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    logic [31:0]           lfsr = 32'hde47_408b;
    serial_bus_pkg::data_t model [serial_bus_pkg::MEM_DEPTH];
    serial_bus_pkg::data_t got_q [$];
    serial_bus_pkg::addr_t addr_q [$];
    serial_bus_pkg::addr_t single_addr;
    serial_bus_pkg::addr_t base;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int cycles = 0;
    int err_start;

    serial_slave #(.SLAVE_ID(2'd1)) uut (
        .clk(clk), .rstN(rstN), .control(control), .wD(wD),
        .valid(valid), .last(last), .rD(rD), .ready(ready)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic serial_bus_pkg::data_t expected_word(input serial_bus_pkg::addr_t a);
        return model[a];
    endfunction

    // start code, id, rw, burst, address, msb first, then one idle cycle
    task automatic send_frame(input logic [1:0] id, input logic rw, input logic burst,
                              input serial_bus_pkg::addr_t a);
        logic [17:0] f;
        f = {3'b111, id, rw, burst, a};
        for (int b = 17; b >= 0; b--) begin
            @(posedge clk);
            #1 control = f[b];
        end
        @(posedge clk);
        #1 control = 1'b0;
    endtask

    task automatic write_words(input serial_bus_pkg::addr_t a, input int n,
                               input bit gaps, input bit record);
        serial_bus_pkg::data_t w;
        int gap;
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            w = rand_bits(32);
            if (record) model[a + i] = w;
            for (int b = 31; b >= 0; b--) begin
                gap = gaps ? int'(rand_bits(2)) : 0;
                repeat (gap) begin
                    @(posedge clk);
                    #1 valid = 1'b0;
                end
                @(posedge clk);
                #1 wD = w[b];
                valid = 1'b1;
                last  = (i == n - 1);
            end
        end
        @(posedge clk);
        #1 valid = 1'b0;
        last = 1'b0;
        wD   = 1'b0;
    endtask

    // ready falls after the command, then one run of 32 high cycles per word
    task automatic read_words(input serial_bus_pkg::addr_t a, input int n);
        serial_bus_pkg::data_t got;
        int run;
        last = (n == 1);
        @(negedge clk);
        while (ready) @(negedge clk);
        for (int i = 0; i < n; i++) begin
            while (!ready) @(negedge clk);
            run = 0;
            got = '0;
            while (ready && run < 32) begin
                got = {got[30:0], rD};
                run++;
                @(negedge clk);
            end
            got_q.push_back(got);
            addr_q.push_back(serial_bus_pkg::addr_t'(a + i));
            checks++;
            assert (run == 32 && (ready == (i == n - 1))) else begin
                $display("Fail at %0t: word %0d ready run %0d cycles then ready=%b, expected 32",
                         $time, i, run, ready);
                errors++;
            end
            if (i == n - 2) begin
                @(posedge clk);
                #1 last = 1'b1;
            end
        end
        // an extra fetch gap here would mean one run too many
        repeat (40) begin
            checks++;
            assert (ready) else begin
                $display("Fail at %0t: ready dropped after the final word of the burst", $time);
                errors++;
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1 last = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) $display("%s: ok", name);
        else $display("%s: %0d error(s)", name, errors - err_before);
    endtask

    // compares each collected read word with the model
    always @(posedge clk) begin
        serial_bus_pkg::addr_t a;
        serial_bus_pkg::data_t g;
        while (got_q.size() > 0) begin
            g = got_q.pop_front();
            a = addr_q.pop_front();
            checks++;
            assert (g === expected_word(a)) else begin
                $display("Fail at %0t: addr %0d read %h expected %h",
                         $time, a, g, expected_word(a));
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        control = 1'b0;
        wD = 1'b0;
        valid = 1'b0;
        last = 1'b0;
        repeat (10) @(posedge clk);
        #1 rstN = 1'b1;

        err_start = errors;
        @(negedge clk);
        checks++;
        assert (ready === 1'b1 && rD === 1'b0) else begin
            $display("Fail at %0t: after reset ready=%b rD=%b", $time, ready, rD);
            errors++;
        end
        report_test("test 1 reset state", err_start);

        err_start = errors;
        single_addr = serial_bus_pkg::addr_t'(rand_bits(11) % serial_bus_pkg::MEM_DEPTH);
        send_frame(2'd1, 1'b1, 1'b0, single_addr);
        write_words(single_addr, 1, 1'b0, 1'b1);
        send_frame(2'd1, 1'b0, 1'b0, single_addr);
        read_words(single_addr, 1);
        report_test("test 2 single write and read", err_start);

        err_start = errors;
        base = serial_bus_pkg::addr_t'(rand_bits(11) % (serial_bus_pkg::MEM_DEPTH - 4));
        send_frame(2'd1, 1'b1, 1'b1, base);
        write_words(base, 4, 1'b0, 1'b1);
        send_frame(2'd1, 1'b0, 1'b1, base);
        read_words(base, 4);
        report_test("test 3 burst of 4", err_start);

        // wrong slave id, so the word must not land in memory
        err_start = errors;
        send_frame(2'd2, 1'b1, 1'b0, single_addr);
        write_words(single_addr, 1, 1'b0, 1'b0);
        send_frame(2'd1, 1'b0, 1'b0, single_addr);
        read_words(single_addr, 1);
        report_test("test 4 other slave id ignored", err_start);

        err_start = errors;
        base = serial_bus_pkg::addr_t'(rand_bits(11) % serial_bus_pkg::MEM_DEPTH);
        send_frame(2'd1, 1'b1, 1'b0, base);
        write_words(base, 1, 1'b1, 1'b1);
        send_frame(2'd1, 1'b0, 1'b0, base);
        read_words(base, 1);
        report_test("test 5 write with valid gaps", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/serial_bus_pkg.sv
rtl/frame_receiver.sv
rtl/write_deserializer.sv
rtl/transfer_controller.sv
rtl/word_memory.sv
rtl/read_serializer.sv
rtl/serial_slave.sv
sim/serial_slave_tb.sv
